/* verilog/host_bridge_pkg.sv */
package host_bridge_pkg;

  localparam int byte_w      = 8;   // one host byte
  localparam int word_w      = 16;  // memory data word
  localparam int addr_w      = 24;  // three address bytes
  localparam int frame_bits  = 16;  // payload bits after the start bit
  localparam int sync_stages = 2;   // flops per synchronised host line

  // command codes, one byte each
  localparam logic [byte_w-1:0] cmd_none        = 8'h00;
  localparam logic [byte_w-1:0] cmd_set_data_lo = 8'h10;  // wdata[7:0]
  localparam logic [byte_w-1:0] cmd_set_data_hi = 8'h11;  // wdata[15:8]
  localparam logic [byte_w-1:0] cmd_set_addr0   = 8'h12;  // addr[7:0]
  localparam logic [byte_w-1:0] cmd_set_addr1   = 8'h13;
  localparam logic [byte_w-1:0] cmd_set_addr2   = 8'h14;  // addr[23:16]
  localparam logic [byte_w-1:0] cmd_mode_sd     = 8'h21;  // 640x480
  localparam logic [byte_w-1:0] cmd_mode_hd     = 8'h22;  // 1024x768
  localparam logic [byte_w-1:0] cmd_mem_write   = 8'hA0;
  localparam logic [byte_w-1:0] cmd_mem_read    = 8'hA1;  // answers with a reply

  // one received host frame
  typedef struct packed {
    logic [byte_w-1:0] code;  // sent first on the line
    logic [byte_w-1:0] arg;
  } host_frame_t;

  // single-word memory request, held until ack
  typedef struct packed {
    logic              read;
    logic              write;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
  } mem_req_t;

endpackage

/* verilog/strobe_sync.sv */
module strobe_sync import host_bridge_pkg::*; (
  input  logic sys_clk,
  input  logic sys_rst_n,
  input  logic host_strobe,
  input  logic host_bit,
  output logic strobe_rise,
  output logic bit_sync
);

  logic [sync_stages-1:0] strobe_meta;  // strobe sync chain
  logic [sync_stages-1:0] bit_meta;     // bit sync chain
  logic                   strobe_prev;  // edge register

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      strobe_meta <= '0;
      bit_meta    <= '0;
      strobe_prev <= 1'b0;
      strobe_rise <= 1'b0;
      bit_sync    <= 1'b0;
    end else begin
      strobe_meta <= {strobe_meta[sync_stages-2:0], host_strobe};
      bit_meta    <= {bit_meta[sync_stages-2:0], host_bit};
      strobe_prev <= strobe_meta[sync_stages-1];
      strobe_rise <= strobe_meta[sync_stages-1] & ~strobe_prev;  // 3 cycles after raw edge
      bit_sync    <= bit_meta[sync_stages-1];  // same depth as the pulse
    end
  end

endmodule

/* verilog/host_frame_rx.sv */
module host_frame_rx import host_bridge_pkg::*; (
  input  logic        sys_clk,
  input  logic        sys_rst_n,
  input  logic        strobe_rise,
  input  logic        bit_sync,
  input  logic        frame_taken,
  output logic        frame_valid,
  output host_frame_t frame
);

  logic                  rx_active;  // between start bit and last payload bit
  logic [4:0]            bit_cnt;    // payload bits received so far
  logic [frame_bits-1:0] shift_q;
  logic [frame_bits-1:0] shift_nxt;
  logic                  last_bit;

  assign shift_nxt = {bit_sync, shift_q[frame_bits-1:1]};  // lsb first
  assign last_bit  = rx_active && strobe_rise && (bit_cnt == 5'(frame_bits - 1));

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rx_active   <= 1'b0;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end else begin
      if (frame_taken) begin
        frame_valid <= 1'b0;
      end
      if (!rx_active) begin
        // start bit only when the last frame is gone
        if (strobe_rise && bit_sync && !frame_valid) begin
          rx_active <= 1'b1;
          bit_cnt   <= '0;
        end
      end else if (last_bit) begin
        rx_active   <= 1'b0;
        frame_valid <= 1'b1;  // held until taken
      end else if (strobe_rise) begin
        bit_cnt <= bit_cnt + 5'd1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rx_active && strobe_rise) begin
      shift_q <= shift_nxt;
    end
    if (last_bit) begin
      frame.code <= shift_nxt[byte_w-1:0];           // first byte on the line
      frame.arg  <= shift_nxt[frame_bits-1:byte_w];
    end
  end

  // engine may sample the frame any time until it takes it
  assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    frame_valid && !frame_taken |=> $stable(frame))
    else $error("frame changed while waiting for the engine");

endmodule

/* verilog/host_reply_tx.sv */
module host_reply_tx import host_bridge_pkg::*; (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              strobe_rise,
  input  logic              reply_start,
  input  logic [word_w-1:0] reply_word,
  output logic              reply_bit
);

  logic              tx_active;
  logic [4:0]        bit_cnt;  // 0 start, 1..16 data, 17 stop
  logic [word_w-1:0] shift_q;
  logic              tx_step;

  assign tx_step = tx_active && strobe_rise;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      tx_active <= 1'b0;
      bit_cnt   <= '0;
      reply_bit <= 1'b0;
    end else if (reply_start) begin
      tx_active <= 1'b1;
      bit_cnt   <= '0;
    end else if (tx_step) begin
      bit_cnt <= bit_cnt + 5'd1;
      if (bit_cnt == 5'd0) begin
        reply_bit <= 1'b1;  // start bit
      end else if (bit_cnt == 5'(word_w + 1)) begin
        reply_bit <= 1'b0;  // stop bit, line back to idle
        tx_active <= 1'b0;
      end else begin
        reply_bit <= shift_q[0];
      end
    end
  end

  // word shifts out lsb first after the start bit
  always_ff @(posedge sys_clk) begin
    if (reply_start) begin
      shift_q <= reply_word;
    end else if (tx_step && bit_cnt != 5'd0) begin
      shift_q <= shift_q >> 1;
    end
  end

  assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    !tx_active |-> !reply_bit)
    else $error("reply line high while transmitter idle");

endmodule

/* verilog/command_engine.sv */
module command_engine import host_bridge_pkg::*; (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              frame_valid,
  input  host_frame_t       frame,
  output logic              frame_taken,
  output mem_req_t          mem_req,
  input  logic              mem_ack,
  input  logic [word_w-1:0] mem_rdata,
  output logic              reply_start,
  output logic [word_w-1:0] reply_word,
  output logic              video_mode_hd,
  output logic              busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_exec,  // decode and run one command
    st_mem    // waiting for mem_ack
  } state_t;

  state_t            state;
  logic [byte_w-1:0] code_q;
  logic [byte_w-1:0] arg_q;
  logic [byte_w-1:0] data_lo;
  logic [byte_w-1:0] data_hi;
  logic [byte_w-1:0] addr0;
  logic [byte_w-1:0] addr1;
  logic [byte_w-1:0] addr2;
  logic              req_read;
  logic              req_write;
  logic [addr_w-1:0] req_addr;
  logic [word_w-1:0] req_wdata;
  logic              is_mem_code;

  assign frame_taken = frame_valid && (state == st_idle);
  assign busy        = (state != st_idle);
  assign is_mem_code = (code_q == cmd_mem_write) || (code_q == cmd_mem_read);

  assign mem_req = '{read: req_read, write: req_write, addr: req_addr, wdata: req_wdata};

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state         <= st_idle;
      code_q        <= cmd_none;
      arg_q         <= '0;
      data_lo       <= '0;
      data_hi       <= '0;
      addr0         <= '0;
      addr1         <= '0;
      addr2         <= '0;
      video_mode_hd <= 1'b0;
      req_read      <= 1'b0;
      req_write     <= 1'b0;
      reply_start   <= 1'b0;
    end else begin
      reply_start <= 1'b0;
      case (state)
        st_idle: begin
          if (frame_taken) begin
            code_q <= frame.code;
            arg_q  <= frame.arg;
            state  <= st_exec;
          end
        end
        st_exec: begin
          state <= st_idle;  // most codes finish here
          case (code_q)
            cmd_set_data_lo: data_lo <= arg_q;
            cmd_set_data_hi: data_hi <= arg_q;
            cmd_set_addr0:   addr0   <= arg_q;
            cmd_set_addr1:   addr1   <= arg_q;
            cmd_set_addr2:   addr2   <= arg_q;
            cmd_mode_sd:     video_mode_hd <= 1'b0;
            cmd_mode_hd:     video_mode_hd <= 1'b1;
            cmd_mem_write: begin
              req_write <= 1'b1;
              state     <= st_mem;
            end
            cmd_mem_read: begin
              req_read <= 1'b1;
              state    <= st_mem;
            end
            default: ;  // unknown code, done with no effect
          endcase
        end
        st_mem: begin
          if (mem_ack) begin
            req_read    <= 1'b0;
            req_write   <= 1'b0;
            reply_start <= req_read;  // only reads answer the host
            state       <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == st_exec && is_mem_code) begin
      req_addr  <= {addr2, addr1, addr0};
      req_wdata <= {data_hi, data_lo};
    end
    if (state == st_mem && mem_ack) begin
      reply_word <= mem_rdata;  // rdata only valid with the ack
    end
  end

  assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    !(mem_req.read && mem_req.write))
    else $error("read and write requested together");

  // memory side may sample any cycle before it acks
  assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    (mem_req.read || mem_req.write) && !mem_ack |=> $stable(mem_req))
    else $error("memory request changed before ack");

endmodule

/* verilog/host_bridge_top.sv */
module host_bridge_top import host_bridge_pkg::*; (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              host_strobe,
  input  logic              host_bit,
  output logic              reply_bit,
  output mem_req_t          mem_req,
  input  logic              mem_ack,
  input  logic [word_w-1:0] mem_rdata,
  output logic              video_mode_hd,
  output logic              busy
);

  logic              strobe_rise;  // one pulse per host strobe
  logic              bit_sync;
  logic              frame_valid;
  logic              frame_taken;
  host_frame_t       frame;
  logic              reply_start;
  logic [word_w-1:0] reply_word;

  strobe_sync u_strobe_sync (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .host_strobe (host_strobe),
    .host_bit    (host_bit),
    .strobe_rise (strobe_rise),
    .bit_sync    (bit_sync)
  );

  host_frame_rx u_frame_rx (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .strobe_rise (strobe_rise),
    .bit_sync    (bit_sync),
    .frame_taken (frame_taken),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  host_reply_tx u_reply_tx (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .strobe_rise (strobe_rise),  // reply shares the host strobe
    .reply_start (reply_start),
    .reply_word  (reply_word),
    .reply_bit   (reply_bit)
  );

  command_engine u_engine (
    .sys_clk       (sys_clk),
    .sys_rst_n     (sys_rst_n),
    .frame_valid   (frame_valid),
    .frame         (frame),
    .frame_taken   (frame_taken),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .reply_start   (reply_start),
    .reply_word    (reply_word),
    .video_mode_hd (video_mode_hd),
    .busy          (busy)
  );

endmodule

/* bench/host_bridge_tb.sv */
module host_bridge_tb import host_bridge_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic              sys_clk = 1'b0;
  logic              sys_rst_n = 1'b0;
  logic              host_strobe = 1'b0;
  logic              host_bit = 1'b0;
  logic              reply_bit;
  mem_req_t          mem_req;
  logic              mem_ack = 1'b0;
  logic [word_w-1:0] mem_rdata = '0;
  logic              video_mode_hd;
  logic              busy;

  int                check_errors = 0;
  int                other_errors = 0;
  logic              timed_out = 1'b0;
  int                cycle_count = 0;
  int                cycle_limit = 0;  // set once the stimulus is read
  logic [31:0]       rng_state = 32'he961_b67b;
  logic [3:0]        wait_cnt = '0;    // cycles left until ack
  logic              busy_ok = 1'b1;
  logic [word_w-1:0] preload_mem [logic [addr_w-1:0]];
  logic [word_w-1:0] written_mem [logic [addr_w-1:0]];
  logic              log_write [$];    // one entry per acked request
  logic [addr_w-1:0] log_addr [$];
  logic [word_w-1:0] log_data [$];
  logic              log_busy_ok [$];
  int                req_idx = 0;      // next request entry to match
  logic [17:0]       last_reply = '0;  // start, word, stop
  logic              reply_ready = 1'b0;

  host_bridge_top i_dut (
    .sys_clk       (sys_clk),
    .sys_rst_n     (sys_rst_n),
    .host_strobe   (host_strobe),
    .host_bit      (host_bit),
    .reply_bit     (reply_bit),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .video_mode_hd (video_mode_hd),
    .busy          (busy)
  );

  always #50 sys_clk = ~sys_clk;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [word_w-1:0] read_word(input logic [addr_w-1:0] addr);
    if (written_mem.exists(addr)) return written_mem[addr];
    if (preload_mem.exists(addr)) return preload_mem[addr];
    return addr[15:0] ^ {addr[23:16], addr[23:16]} ^ 16'h5a5a;  // untouched words
  endfunction

  // memory behind the request port with random ack latency
  always @(posedge sys_clk) begin
    if (!sys_rst_n) begin
      mem_ack  <= 1'b0;
      wait_cnt <= '0;
    end else begin
      mem_ack <= 1'b0;
      if (wait_cnt != 4'd0) begin
        if (!busy) busy_ok = 1'b0;
        if (wait_cnt == 4'd1) begin
          mem_ack   <= 1'b1;
          mem_rdata <= read_word(mem_req.addr);
          if (mem_req.write) written_mem[mem_req.addr] = mem_req.wdata;
          log_write.push_back(mem_req.write);
          log_addr.push_back(mem_req.addr);
          log_data.push_back(mem_req.wdata);
          log_busy_ok.push_back(busy_ok);
        end
        wait_cnt <= wait_cnt - 4'd1;
      end else if (!mem_ack && (mem_req.read || mem_req.write)) begin
        rng_state = next_random(rng_state);
        wait_cnt <= 4'(rng_state[2:0]) + 4'd1;  // 1 to 8 cycles
        busy_ok = busy;
      end
    end
  end

  task end_run;
    $display("errors: %0d failed checks, %0d other, timeout %0d",
             check_errors, other_errors, timed_out);
    if (check_errors == 0 && other_errors == 0 && !timed_out) $display("TEST OK");
    else $display("TEST FAILED");
    $finish;
  endtask

  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      timed_out = 1'b1;
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      end_run();
    end
  end

  task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // one strobe period of 6 cycles low and 6 high
  task strobe_once(input logic bit_val, output logic reply_sample);
    @(posedge sys_clk);
    host_strobe <= 1'b0;
    host_bit    <= bit_val;  // only changes while strobe is low
    repeat (5) @(posedge sys_clk);
    @(posedge sys_clk);
    host_strobe <= 1'b1;
    repeat (5) @(posedge sys_clk);
    @(negedge sys_clk);
    reply_sample = reply_bit;  // settled late in the high phase
  endtask

  task send_frame(input logic [byte_w-1:0] code, input logic [byte_w-1:0] arg);
    logic [frame_bits:0] bits;
    logic                sampled;
    bits = {arg, code, 1'b1};  // start bit goes first
    repeat (frame_bits + 1) begin
      strobe_once(bits[0], sampled);
      check_value("reply_bit", 32'd0, 32'(sampled));  // no reply expected here
      bits = bits >> 1;
    end
  endtask

  task collect_reply;
    logic sampled;
    repeat (18) begin
      strobe_once(1'b0, sampled);
      last_reply = {sampled, last_reply[17:1]};
    end
  endtask

  task wait_command_done;
    int n;
    n = 0;
    while (!busy && n < 8) begin
      @(negedge sys_clk);
      n++;
    end
    if (!busy) begin
      other_errors++;
      $display("busy never rose after a frame was sent");
    end
    while (busy) @(negedge sys_clk);
  endtask

  task check_request(input logic is_write, input logic [31:0] addr, input logic [31:0] data);
    if (req_idx >= log_write.size()) begin
      other_errors++;
      $display("no memory request was issued for the access at %h (write %0d)", addr, is_write);
    end else begin
      check_value("mem_req.write", 32'(is_write), 32'(log_write[req_idx]));
      check_value("mem_req.addr", addr, 32'(log_addr[req_idx]));
      if (is_write) check_value("mem_req.wdata", data, 32'(log_data[req_idx]));
      check_value("busy while waiting for mem_ack", 32'd1, 32'(log_busy_ok[req_idx]));
      req_idx++;
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          c;
    int          frames;
    logic [7:0]  op;
    logic [31:0] fa;
    logic [31:0] fb;
    logic [7:0]  op_q [$];
    logic [31:0] a_q [$];
    logic [31:0] b_q [$];
    frames = 0;
    fd = $fopen("bench/host_stimulus.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open bench/host_stimulus.txt");
    end else begin
      n = $fscanf(fd, " %c", op);
      while (n == 1) begin
        if (op == "#") begin
          c = $fgetc(fd);
          while (c != 10 && c != -1) c = $fgetc(fd);
        end else if ($fscanf(fd, " %h %h", fa, fb) != 2) begin
          other_errors++;
          $display("malformed stimulus line for op %c", op);
        end else if (op == "P") begin
          preload_mem[fa[addr_w-1:0]] = fb[word_w-1:0];
        end else begin
          op_q.push_back(op);
          a_q.push_back(fa);
          b_q.push_back(fb);
          if (op == "S") frames++;
        end
        n = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
    end
    cycle_limit = frames * 40 * 12 + 1000;

    repeat (8) @(posedge sys_clk);
    sys_rst_n <= 1'b1;
    @(negedge sys_clk);
    check_value("busy", 32'd0, 32'(busy));
    check_value("video_mode_hd", 32'd0, 32'(video_mode_hd));
    check_value("mem_req.read", 32'd0, 32'(mem_req.read));
    check_value("mem_req.write", 32'd0, 32'(mem_req.write));
    check_value("reply_bit", 32'd0, 32'(reply_bit));

    for (int i = 0; i < op_q.size(); i++) begin
      fa = a_q[i];
      fb = b_q[i];
      case (op_q[i])
        "S": begin
          check_value("unmatched mem_req count", 32'd0, 32'(log_write.size() - req_idx));
          send_frame(fa[byte_w-1:0], fb[byte_w-1:0]);
          wait_command_done();
          if (fa[byte_w-1:0] == cmd_mem_read) begin
            collect_reply();
            reply_ready = 1'b1;
          end
        end
        "M": check_value("video_mode_hd", fa, 32'(video_mode_hd));
        "W": check_request(1'b1, fa, fb);
        "R": begin
          check_request(1'b0, fa, fb);
          if (!reply_ready) begin
            other_errors++;
            $display("no reply was collected before the expected reply %h", fb);
          end else begin
            check_value("reply_bit start", 32'd1, 32'(last_reply[0]));
            check_value("reply_bit word", fb, 32'(last_reply[16:1]));
            check_value("reply_bit stop", 32'd0, 32'(last_reply[17]));
          end
          reply_ready = 1'b0;
        end
        default: begin
          other_errors++;
          $display("unknown op letter %c in the stimulus file", op_q[i]);
        end
      endcase
    end
    check_value("unmatched mem_req count", 32'd0, 32'(log_write.size() - req_idx));
    end_run();
  end

endmodule

/* list.f */
verilog/host_bridge_pkg.sv
verilog/strobe_sync.sv
verilog/host_frame_rx.sv
verilog/host_reply_tx.sv
verilog/command_engine.sv
verilog/host_bridge_top.sv
bench/host_bridge_tb.sv

/* run.sh */
#!/bin/sh
# builds the host bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -j 0 \
  --top-module host_bridge_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vhost_bridge_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

/* bench/host_stimulus.txt */
# op a b : S code arg, M mode 0, W addr data, R addr word, P addr data
# all fields hex, P lines preload the memory model before reset
P 123456 1111
P 123457 2222
P 123556 3333
P 133456 4444
M 0 0
S 22 00
M 1 0
S 21 00
M 0 0
S 22 00
M 1 0
# write ABCD to 102030 and read it back
S 10 CD
S 11 AB
S 12 30
S 13 20
S 14 10
S A0 00
W 102030 ABCD
S A1 00
R 102030 ABCD
S 10 01
S 11 80
S 12 31
S A0 00
W 102031 8001
S A1 00
R 102031 8001
S 12 30
S A1 00
R 102030 ABCD
# unknown codes, no request and no reply
S 55 AA
S 00 00
M 1 0
# preloaded words, each address byte changed once
S 12 56
S 13 34
S 14 12
S A1 00
R 123456 1111
S 12 57
S A1 00
R 123457 2222
S 12 56
S 13 35
S A1 00
R 123556 3333
S 13 34
S 14 13
S A1 00
R 133456 4444
S 21 00
M 0 0
